// File: hdl/abus_port.sv
/*
 * Console A-bus front end
 * Chip-select synchronizer with read/write start pulses, window decode
 * and the console read data select
 */
`timescale 1ns/1ps

module abus_port (
	input  logic             mclk,
	input  logic             st_ale,
	input  ssm_pkg::sat_bus_t sat,
	input  ssm_pkg::word_t   cdc_rdata,
	input  ssm_pkg::word_t   sys_rdata,
	output ssm_pkg::sat_req_t req,
	output ssm_pkg::word_t   sat_rdata
);
	import ssm_pkg::*;

	// Stage 0 is the first flop after the pin
	logic [4:0] cs_sync;
	logic       cdc_q;

	////////////////////////////////////////////////////////////
	// Chip-select synchronizer
	////////////////////////////////////////////////////////////

	// Idle high, chain shifts toward stage 4
	always_ff @(posedge mclk or posedge st_ale)
	begin
		if (st_ale)
			cs_sync <= '1;
		else
			cs_sync <= {cs_sync[3:0], sat.cs2_n};
	end

	// Read start on the falling edge seen at stage 2
	assign req.rd_start = cs_sync[2] & ~cs_sync[1] & ~sat.rd_n;

	// Write starts later so wdata has settled
	assign req.wr_start = cs_sync[4] & ~cs_sync[3] & ~sat.wr_n;

	////////////////////////////////////////////////////////////
	// Window decode
	////////////////////////////////////////////////////////////

	assign req.cdc_sel = ~sat.cs2_n && (sat.addr[14:12] == WIN_CDC);
	assign req.reg_sel = ~sat.cs2_n && (sat.addr[14:12] == WIN_REG);
	assign req.reg_idx = sat.addr[5:2];
	assign req.half    = sat.addr[1];

	////////////////////////////////////////////////////////////
	// Read data select
	////////////////////////////////////////////////////////////

	// Window choice lines up with the registered sub-block data
	always_ff @(posedge mclk)
	begin
		cdc_q     <= req.cdc_sel;
		sat_rdata <= cdc_q ? cdc_rdata : sys_rdata;
	end

endmodule

// File: hdl/cd_mailbox.sv
/*
 * CD block mailbox
 * Command registers, hirq and its mask, in-command flag,
 * CDC window read mux and the console interrupt
 */
`timescale 1ns/1ps

module cd_mailbox (
	input  logic                 mclk,
	input  logic                 st_ale,
	input  ssm_pkg::sat_req_t    req,
	input  ssm_pkg::word_t       sat_wdata,
	input  ssm_pkg::host_pulse_t host_pulses,
	input  ssm_pkg::word_t       resp [4],
	input  ssm_pkg::word_t       fifo_q,
	output ssm_pkg::word_t       cr_words [4],
	output ssm_pkg::word_t       hirq,
	output ssm_pkg::word_t       hirq_mask,
	output logic                 in_cmd,
	output logic                 cdc_set,
	output ssm_pkg::word_t       cdc_rdata,
	output logic                 sat_irq
);
	import ssm_pkg::*;

	logic wr;
	logic rd;

	assign wr = req.wr_start & req.cdc_sel;
	assign rd = req.rd_start & req.cdc_sel;

	// CR4 write closes a command
	assign cdc_set = wr && (req.reg_idx == CI_CR4);

	////////////////////////////////////////////////////////////
	// Command registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge mclk)
	begin
		if (wr)
		begin
			case (req.reg_idx)
				CI_CR1:  cr_words[0] <= sat_wdata;
				CI_CR2:  cr_words[1] <= sat_wdata;
				CI_CR3:  cr_words[2] <= sat_wdata;
				CI_CR4:  cr_words[3] <= sat_wdata;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// hirq, mask and in-command
	////////////////////////////////////////////////////////////

	always_ff @(posedge mclk or posedge st_ale)
	begin
		if (st_ale)
		begin
			hirq      <= '0;
			hirq_mask <= '0;
			in_cmd    <= 1'b0;
		end
		else
		begin
			// Host set, then host clear, then console AND
			if (host_pulses.hirq_set)
				hirq <= hirq | host_pulses.wdata;
			else if (host_pulses.hirq_clr)
				hirq <= hirq & ~host_pulses.wdata;
			else if (wr && (req.reg_idx == CI_HIRQ))
				hirq <= hirq & sat_wdata;
			if (wr && (req.reg_idx == CI_MASK))
				hirq_mask <= sat_wdata;
			// Console read of CR4 ends the command
			if (rd && (req.reg_idx == CI_CR4))
				in_cmd <= 1'b0;
			else if (cdc_set)
				in_cmd <= 1'b1;
		end
	end

	assign sat_irq = |(hirq & hirq_mask);

	////////////////////////////////////////////////////////////
	// CDC window read mux
	////////////////////////////////////////////////////////////

	// CR slots read back the host responses
	always_ff @(posedge mclk)
	begin
		case (req.reg_idx)
			CI_FIFO: cdc_rdata <= {fifo_q[7:0], fifo_q[15:8]};
			CI_HIRQ: cdc_rdata <= hirq;
			CI_MASK: cdc_rdata <= hirq_mask;
			CI_CR1:  cdc_rdata <= resp[0];
			CI_CR2:  cdc_rdata <= resp[1];
			CI_CR3:  cdc_rdata <= resp[2];
			CI_CR4:  cdc_rdata <= resp[3];
			default: cdc_rdata <= '0;
		endcase
	end

endmodule

// File: hdl/cdc_fifo.sv
/*
 * CDC data FIFO
 * Show-ahead synchronous FIFO with used-word count
 */
`timescale 1ns/1ps

module cdc_fifo #(
	parameter int FIFO_AW = 10
) (
	input  logic             mclk,
	input  logic             clr,
	input  logic             push,
	input  logic             pop,
	input  ssm_pkg::word_t   wdata,
	output ssm_pkg::word_t   q,
	output logic [FIFO_AW:0] used,
	output logic             full,
	output logic             empty
);
	import ssm_pkg::*;

	localparam int DEPTH = 1 << FIFO_AW;

	word_t              mem [DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic               do_push;
	logic               do_pop;

	// Overflow and underflow are dropped
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	// Count tops out at exactly DEPTH
	assign full  = used[FIFO_AW];
	assign empty = (used == '0);

	// Head word always visible
	assign q = mem[rd_ptr];

	always_ff @(posedge mclk)
	begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge mclk)
	begin
		if (clr)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used   <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop keep the count
			if (do_push && !do_pop)
				used <= used + 1'b1;
			else if (do_pop && !do_push)
				used <= used - 1'b1;
		end
	end

endmodule

// File: hdl/host_port.sv
/*
 * Host register port
 * Control and response registers, interrupt flags, host read mux
 * and the host interrupt line
 */
`timescale 1ns/1ps

module host_port #(
	parameter int FIFO_AW = 10
) (
	input  logic                  mclk,
	input  logic                  st_ale,
	input  ssm_pkg::host_bus_t    host,
	input  ssm_pkg::word_t        fifo_q,
	input  logic [FIFO_AW:0]      fifo_used,
	input  logic                  fifo_full,
	input  logic                  fifo_empty,
	input  ssm_pkg::word_t        cr_words [4],
	input  ssm_pkg::word_t        hirq,
	input  ssm_pkg::word_t        hirq_mask,
	input  logic                  in_cmd,
	input  logic                  set_cdc,
	input  logic                  set_cmd,
	input  ssm_pkg::word_t        sys_cmd,
	input  ssm_pkg::word_t        sys_data,
	input  ssm_pkg::word_t        sys_ctrl,
	output ssm_pkg::host_ctrl_t   ctrl,
	output ssm_pkg::word_t        resp [4],
	output ssm_pkg::host_pulse_t  host_pulses,
	output ssm_pkg::word_t        host_rdata,
	output logic                  host_irq
);
	import ssm_pkg::*;

	logic             wr_en;
	logic             stat_wr;
	logic             fifo_evt;
	logic             flag_cdc;
	logic             flag_cmd;
	logic             flag_fifo;
	logic             empty_d;
	logic [FIFO_AW:0] used_d;
	logic [7:0]       addr_q;
	word_t            stat_word;
	word_t            fstat_word;

	////////////////////////////////////////////////////////////
	// Write decode
	////////////////////////////////////////////////////////////

	assign wr_en   = host.cs & host.wr;
	assign stat_wr = wr_en && (host.addr == HA_STAT);

	// Strobes for the console-side blocks and the FIFO
	assign host_pulses.hirq_set  = wr_en && (host.addr == HA_HIRQ_SET);
	assign host_pulses.hirq_clr  = wr_en && (host.addr == HA_HIRQ_CLR);
	assign host_pulses.cmd_clr   = wr_en && (host.addr == HA_SCMD);
	assign host_pulses.data_wr   = wr_en && (host.addr == HA_SDATA);
	assign host_pulses.fifo_push = wr_en && (host.addr == HA_FIFO);
	assign host_pulses.fifo_pop  = host.cs && host.rd && (host.addr == HA_FIFO);
	assign host_pulses.wdata     = host.wdata;

	always_ff @(posedge mclk or posedge st_ale)
	begin
		if (st_ale)
			ctrl <= '0;
		else if (wr_en && (host.addr == HA_CTRL))
			ctrl <= host_ctrl_t'(host.wdata);
	end

	// Four response words, address bits 2..1 pick the slot
	always_ff @(posedge mclk)
	begin
		if (wr_en && (host.addr[7:3] == HA_RESPW[7:3]))
			resp[host.addr[2:1]] <= host.wdata;
	end

	////////////////////////////////////////////////////////////
	// Interrupt flags
	////////////////////////////////////////////////////////////

	// FIFO went empty, dropped below 256 or reached 1024
	assign fifo_evt = (fifo_empty && !empty_d)
		|| ((used_d >= 256) && (fifo_used < 256))
		|| ((used_d < 1024) && (fifo_used >= 1024));

	// Event wins over a write-one clear in the same cycle
	always_ff @(posedge mclk or posedge st_ale)
	begin
		if (st_ale)
		begin
			flag_cdc  <= 1'b0;
			flag_cmd  <= 1'b0;
			flag_fifo <= 1'b0;
			empty_d   <= 1'b1;
			used_d    <= '0;
		end
		else
		begin
			empty_d <= fifo_empty;
			used_d  <= fifo_used;
			if (set_cdc)
				flag_cdc <= 1'b1;
			else if (stat_wr && host.wdata[0])
				flag_cdc <= 1'b0;
			if (set_cmd)
				flag_cmd <= 1'b1;
			else if (stat_wr && host.wdata[1])
				flag_cmd <= 1'b0;
			if (fifo_evt)
				flag_fifo <= 1'b1;
			else if (stat_wr && host.wdata[2])
				flag_fifo <= 1'b0;
		end
	end

	assign host_irq = (flag_cdc & ctrl.irq_cdc_en)
		| (flag_cmd & ctrl.irq_cmd_en)
		| (flag_fifo & ctrl.irq_fifo_en);

	////////////////////////////////////////////////////////////
	// Host read mux
	////////////////////////////////////////////////////////////

	assign stat_word  = {1'b0, host_irq, 1'b0, in_cmd, 9'b0, flag_fifo, flag_cmd, flag_cdc};
	assign fstat_word = word_t'({fifo_full, fifo_used});

	// Address latched first, data one edge later
	always_ff @(posedge mclk)
	begin
		addr_q <= host.addr;
		case (addr_q)
			HA_ID:       host_rdata <= ID_WORD;
			HA_VER:      host_rdata <= VER_WORD;
			HA_CTRL:     host_rdata <= word_t'(ctrl);
			HA_STAT:     host_rdata <= stat_word;
			// Head word, popping is left to the rd strobe
			HA_FIFO:     host_rdata <= fifo_q;
			HA_FSTAT:    host_rdata <= fstat_word;
			HA_SCMD:     host_rdata <= sys_cmd;
			HA_SDATA:    host_rdata <= sys_data;
			HA_SCTRL:    host_rdata <= sys_ctrl;
			HA_RESP, HA_RESP + 8'd2, HA_RESP + 8'd4, HA_RESP + 8'd6:
				host_rdata <= resp[addr_q[2:1]];
			HA_CR, HA_CR + 8'd2, HA_CR + 8'd4, HA_CR + 8'd6:
				host_rdata <= cr_words[addr_q[2:1]];
			HA_HIRQ_SET: host_rdata <= hirq;
			HA_MASK:     host_rdata <= hirq_mask;
			default:     host_rdata <= 16'hffff;
		endcase
	end

endmodule

// File: hdl/sat_sysregs.sv
/*
 * Console system registers
 * ctrl, cmd and data registers, free-running timer and their read mux
 */
`timescale 1ns/1ps

module sat_sysregs #(
	parameter int FIFO_AW   = 10,
	parameter int TIMER_DIV = 100
) (
	input  logic                 mclk,
	input  logic                 st_ale,
	input  ssm_pkg::sat_req_t    req,
	input  ssm_pkg::word_t       sat_wdata,
	input  ssm_pkg::host_pulse_t host_pulses,
	input  ssm_pkg::word_t       fifo_q,
	input  logic [FIFO_AW:0]     fifo_used,
	input  logic                 fifo_full,
	output ssm_pkg::word_t       ctrl,
	output ssm_pkg::word_t       cmd,
	output ssm_pkg::word_t       data,
	output logic                 cmd_set,
	output ssm_pkg::word_t       sys_rdata
);
	import ssm_pkg::*;

	localparam int DIV_W = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;

	logic             wr;
	logic [DIV_W-1:0] div_cnt;
	logic [31:0]      timer;

	assign wr      = req.wr_start & req.reg_sel;
	assign cmd_set = wr && (req.reg_idx == SI_CMD);

	always_ff @(posedge mclk or posedge st_ale)
	begin
		if (st_ale)
		begin
			ctrl <= 16'h0100;
			cmd  <= '0;
			data <= '0;
		end
		else
		begin
			if (wr && (req.reg_idx == SI_CTRL))
				ctrl <= sat_wdata;
			// Host clear beats a console write
			if (host_pulses.cmd_clr)
				cmd <= '0;
			else if (cmd_set)
				cmd <= sat_wdata;
			if (wr && (req.reg_idx == SI_DATA))
				data <= sat_wdata;
			else if (host_pulses.data_wr)
				data <= host_pulses.wdata;
		end
	end

	////////////////////////////////////////////////////////////
	// Timer
	////////////////////////////////////////////////////////////

	// Prescaler wraps every TIMER_DIV cycles, timer steps on wrap
	always_ff @(posedge mclk or posedge st_ale)
	begin
		if (st_ale)
		begin
			div_cnt <= '0;
			timer   <= '0;
		end
		else
		begin
			if (div_cnt == DIV_W'(TIMER_DIV - 1))
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
			if (wr && (req.reg_idx == SI_TIMER))
				timer <= '0;
			else if (div_cnt == '0)
				timer <= timer + 32'd1;
		end
	end

	////////////////////////////////////////////////////////////
	// Read mux
	////////////////////////////////////////////////////////////

	always_ff @(posedge mclk)
	begin
		case (req.reg_idx)
			SI_ID:    sys_rdata <= req.half ? VER_WORD : ID_WORD;
			SI_CTRL:  sys_rdata <= ctrl;
			SI_STAT:  sys_rdata <= word_t'({fifo_full, fifo_used});
			// High half first
			SI_TIMER: sys_rdata <= req.half ? timer[15:0] : timer[31:16];
			SI_CMD:   sys_rdata <= cmd;
			SI_DATA:  sys_rdata <= data;
			// Console is big-endian
			SI_FIFO:  sys_rdata <= {fifo_q[7:0], fifo_q[15:8]};
			default:  sys_rdata <= '0;
		endcase
	end

endmodule

// File: hdl/ssm_pkg.sv
/*
 * Register hub shared definitions
 * Host and console bus structs, register offsets, window codes and IDs
 */
package ssm_pkg;

	////////////////////////////////////////////////////////////
	// Bus types
	////////////////////////////////////////////////////////////

	typedef logic [15:0] word_t;

	// Host request, strobes last one cycle
	typedef struct packed {
		logic       cs;
		logic       wr;
		logic       rd;
		logic [7:0] addr;
		word_t      wdata;
	} host_bus_t;

	// Console A-bus pins, active low levels
	typedef struct packed {
		logic        cs2_n;
		logic        rd_n;
		logic        wr_n;
		logic [15:0] addr;
		word_t       wdata;
	} sat_bus_t;

	// Synchronized console access
	typedef struct packed {
		logic       rd_start;
		logic       wr_start;
		logic       cdc_sel;
		logic       reg_sel;
		logic [3:0] reg_idx;
		// Address bit 1, picks the half of a 32-bit pair
		logic       half;
	} sat_req_t;

	// Host control register layout
	typedef struct packed {
		logic [5:0] rsvd_hi;
		logic       fifo_dir;
		logic       fifo_rst;
		logic [4:0] rsvd_lo;
		logic       irq_fifo_en;
		logic       irq_cmd_en;
		logic       irq_cdc_en;
	} host_ctrl_t;

	// Decoded host write and FIFO strobes
	typedef struct packed {
		logic  hirq_set;
		logic  hirq_clr;
		logic  cmd_clr;
		logic  data_wr;
		logic  fifo_push;
		logic  fifo_pop;
		word_t wdata;
	} host_pulse_t;

	////////////////////////////////////////////////////////////
	// Host byte offsets
	////////////////////////////////////////////////////////////

	localparam logic [7:0] HA_ID       = 8'h00;
	localparam logic [7:0] HA_VER      = 8'h02;
	localparam logic [7:0] HA_CTRL     = 8'h04;
	localparam logic [7:0] HA_STAT     = 8'h06;
	localparam logic [7:0] HA_FIFO     = 8'h08;
	localparam logic [7:0] HA_FSTAT    = 8'h0C;
	localparam logic [7:0] HA_SCMD     = 8'h10;
	localparam logic [7:0] HA_SDATA    = 8'h12;
	localparam logic [7:0] HA_SCTRL    = 8'h14;
	// Four words each
	localparam logic [7:0] HA_RESP     = 8'h18;
	localparam logic [7:0] HA_RESPW    = 8'h20;
	localparam logic [7:0] HA_CR       = 8'h20;
	localparam logic [7:0] HA_HIRQ_SET = 8'h28;
	localparam logic [7:0] HA_MASK     = 8'h2A;
	localparam logic [7:0] HA_HIRQ_CLR = 8'h2C;

	////////////////////////////////////////////////////////////
	// Console register indexes and windows
	////////////////////////////////////////////////////////////

	localparam logic [3:0] CI_FIFO  = 4'd0;
	localparam logic [3:0] CI_HIRQ  = 4'd2;
	localparam logic [3:0] CI_MASK  = 4'd3;
	localparam logic [3:0] CI_CR1   = 4'd6;
	localparam logic [3:0] CI_CR2   = 4'd7;
	localparam logic [3:0] CI_CR3   = 4'd8;
	localparam logic [3:0] CI_CR4   = 4'd9;

	localparam logic [3:0] SI_ID    = 4'd0;
	localparam logic [3:0] SI_CTRL  = 4'd1;
	localparam logic [3:0] SI_STAT  = 4'd2;
	localparam logic [3:0] SI_TIMER = 4'd3;
	localparam logic [3:0] SI_CMD   = 4'd4;
	localparam logic [3:0] SI_DATA  = 4'd5;
	localparam logic [3:0] SI_FIFO  = 4'd6;

	// Against address bits 14..12
	localparam logic [2:0] WIN_CDC  = 3'd0;
	localparam logic [2:0] WIN_REG  = 3'd7;

	// "SR" and hardware/firmware version
	localparam word_t ID_WORD  = 16'h5253;
	localparam word_t VER_WORD = 16'h1204;

endpackage

// File: hdl/ssm_top.sv
/*
 * Cartridge register hub top level
 * Wires host port, console front end, mailbox and system registers,
 * and steers the FIFO by direction
 */
`timescale 1ns/1ps

module ssm_top #(
	parameter int FIFO_AW   = 10,
	parameter int TIMER_DIV = 100
) (
	input  logic               mclk,
	input  logic               st_ale,
	input  ssm_pkg::host_bus_t host,
	input  ssm_pkg::sat_bus_t  sat,
	output ssm_pkg::word_t     host_rdata,
	output logic               host_irq,
	output ssm_pkg::word_t     sat_rdata,
	output logic               sat_irq
);
	import ssm_pkg::*;

	sat_req_t         req;
	host_ctrl_t       ctrl;
	host_pulse_t      host_pulses;
	word_t            resp [4];
	word_t            cr_words [4];
	word_t            cdc_rdata;
	word_t            sys_rdata;
	word_t            hirq;
	word_t            hirq_mask;
	word_t            sys_ctrl;
	word_t            sys_cmd;
	word_t            sys_data;
	word_t            fifo_q;
	word_t            fifo_wdata;
	logic [FIFO_AW:0] fifo_used;
	logic             fifo_full;
	logic             fifo_empty;
	logic             fifo_push;
	logic             fifo_pop;
	logic             sat_fifo_sel;
	logic             in_cmd;
	logic             set_cdc;
	logic             set_cmd;

	////////////////////////////////////////////////////////////
	// FIFO steering
	////////////////////////////////////////////////////////////

	assign sat_fifo_sel = req.cdc_sel && (req.reg_idx == CI_FIFO);

	// dir 1: console fills, host drains; dir 0 the reverse
	assign fifo_push = ctrl.fifo_dir ? (req.wr_start & sat_fifo_sel) : host_pulses.fifo_push;
	assign fifo_pop  = ctrl.fifo_dir ? host_pulses.fifo_pop : (req.rd_start & sat_fifo_sel);
	// Console words stored in host byte order
	assign fifo_wdata = ctrl.fifo_dir ? {sat.wdata[7:0], sat.wdata[15:8]} : host_pulses.wdata;

	cdc_fifo #(.FIFO_AW(FIFO_AW)) u_fifo (
		.mclk(mclk), .clr(st_ale | ctrl.fifo_rst), .push(fifo_push), .pop(fifo_pop),
		.wdata(fifo_wdata), .q(fifo_q), .used(fifo_used), .full(fifo_full),
		.empty(fifo_empty)
	);

	////////////////////////////////////////////////////////////
	// Ports and register blocks
	////////////////////////////////////////////////////////////

	abus_port u_abus (
		.mclk(mclk), .st_ale(st_ale), .sat(sat), .cdc_rdata(cdc_rdata),
		.sys_rdata(sys_rdata), .req(req), .sat_rdata(sat_rdata)
	);

	host_port #(.FIFO_AW(FIFO_AW)) u_host (
		.mclk(mclk), .st_ale(st_ale), .host(host), .fifo_q(fifo_q),
		.fifo_used(fifo_used), .fifo_full(fifo_full), .fifo_empty(fifo_empty),
		.cr_words(cr_words), .hirq(hirq), .hirq_mask(hirq_mask), .in_cmd(in_cmd),
		.set_cdc(set_cdc), .set_cmd(set_cmd), .sys_cmd(sys_cmd), .sys_data(sys_data),
		.sys_ctrl(sys_ctrl), .ctrl(ctrl), .resp(resp), .host_pulses(host_pulses),
		.host_rdata(host_rdata), .host_irq(host_irq)
	);

	sat_sysregs #(.FIFO_AW(FIFO_AW), .TIMER_DIV(TIMER_DIV)) u_sys (
		.mclk(mclk), .st_ale(st_ale), .req(req), .sat_wdata(sat.wdata),
		.host_pulses(host_pulses), .fifo_q(fifo_q), .fifo_used(fifo_used),
		.fifo_full(fifo_full), .ctrl(sys_ctrl), .cmd(sys_cmd), .data(sys_data),
		.cmd_set(set_cmd), .sys_rdata(sys_rdata)
	);

	cd_mailbox u_cdc (
		.mclk(mclk), .st_ale(st_ale), .req(req), .sat_wdata(sat.wdata),
		.host_pulses(host_pulses), .resp(resp), .fifo_q(fifo_q), .cr_words(cr_words),
		.hirq(hirq), .hirq_mask(hirq_mask), .in_cmd(in_cmd), .cdc_set(set_cdc),
		.cdc_rdata(cdc_rdata), .sat_irq(sat_irq)
	);

endmodule

// File: list.f
+incdir+test
hdl/ssm_pkg.sv
hdl/cdc_fifo.sv
hdl/abus_port.sv
hdl/host_port.sv
hdl/sat_sysregs.sv
hdl/cd_mailbox.sv
hdl/ssm_top.sv
test/tb_ssm.sv

// File: run.sh
#!/bin/sh
# Build and run the register hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_ssm -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_ssm > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" sim.log; then
	exit 1
fi
exit 0

// File: test/tb_ssm_tasks.svh
/*
 * Register hub testbench tasks
 * Host and console bus access, polls with timeouts and value checks
 */

////////////////////////////////////////////////////////////
// Helpers
////////////////////////////////////////////////////////////

// Wait n edges, then land 1 ns into the cycle
task automatic step(input int n);
	repeat (n) @(posedge mclk);
	#1;
endtask

function automatic word_t rand_word();
	logic [31:0] r;
	r = $random(seed);
	return r[15:0];
endfunction

function automatic word_t swap_bytes(input word_t w);
	return {w[7:0], w[15:8]};
endfunction

// Window in bits 14..12, index in 5..2, half in bit 1
function automatic logic [15:0] sat_addr(input logic [2:0] win, input logic [3:0] idx,
	input logic half);
	return {1'b0, win, 6'b0, idx, half, 1'b0};
endfunction

task automatic check_word(input string name, input word_t got, input word_t exp);
	checks++;
	assert (got === exp)
	else
	begin
		errors++;
		$display("ERROR %s got %h expected %h", name, got, exp);
	end
endtask

task automatic check_true(input logic ok, input string what);
	checks++;
	assert (ok === 1'b1)
	else
	begin
		errors++;
		$display("%s", what);
	end
endtask

task automatic end_test(input string name);
	$display("Test %-8s done: %0d checks, %0d failed", name, checks - mark_checks,
		errors - mark_errors);
	mark_checks = checks;
	mark_errors = errors;
endtask

////////////////////////////////////////////////////////////
// Host bus
////////////////////////////////////////////////////////////

task automatic host_write(input logic [7:0] addr, input word_t data);
	host.cs = 1'b1;
	host.wr = 1'b1;
	host.addr = addr;
	host.wdata = data;
	step(1);
	host.cs = 1'b0;
	host.wr = 1'b0;
endtask

// Data registered two edges after addr, pop strobe only afterwards
task automatic host_read(input logic [7:0] addr, input logic pop, output word_t data);
	host.cs = 1'b1;
	host.addr = addr;
	step(2);
	data = host_rdata;
	if (pop)
	begin
		host.rd = 1'b1;
		step(1);
		host.rd = 1'b0;
	end
	host.cs = 1'b0;
endtask

// Poll host_irq, 20 cycle limit
task automatic wait_host_irq(input logic exp);
	int n;
	n = 0;
	while ((host_irq !== exp) && (n < 20))
	begin
		step(1);
		n++;
	end
	check_true(host_irq === exp,
		$sformatf("host_irq did not reach %0d within 20 cycles", exp));
endtask

////////////////////////////////////////////////////////////
// Console bus
////////////////////////////////////////////////////////////

// Ten cycle access, read data taken at the third edge before a pop shows
task automatic sat_access(input logic write, input logic [15:0] addr, input word_t wdata,
	output word_t rdata);
	sat.cs2_n = 1'b0;
	sat.rd_n = write;
	sat.wr_n = !write;
	sat.addr = addr;
	sat.wdata = wdata;
	step(3);
	rdata = sat_rdata;
	step(7);
	sat.cs2_n = 1'b1;
	sat.rd_n = 1'b1;
	sat.wr_n = 1'b1;
	// Synchronizer back to idle
	step(6);
endtask

task automatic sat_read(input logic [2:0] win, input logic [3:0] idx, input logic half,
	output word_t data);
	sat_access(1'b0, sat_addr(win, idx, half), 16'h0000, data);
endtask

task automatic sat_write(input logic [2:0] win, input logic [3:0] idx, input word_t data);
	word_t unused;
	sat_access(1'b1, sat_addr(win, idx, 1'b0), data, unused);
endtask

// High half first
task automatic read_timer(output logic [31:0] t);
	word_t hi;
	word_t lo;
	sat_read(WIN_REG, SI_TIMER, 1'b0, hi);
	sat_read(WIN_REG, SI_TIMER, 1'b1, lo);
	t = {hi, lo};
endtask

// File: test/tb_ssm.sv
/*
 * Register hub testbench
 * Drives host and console buses through IDs, mailbox, hirq, FIFO
 * and system registers, and prints the closing report
 */
`timescale 1ns/1ps

module tb_ssm;
	import ssm_pkg::*;

	logic      mclk;
	logic      st_ale;
	host_bus_t host;
	sat_bus_t  sat;
	word_t     host_rdata;
	word_t     sat_rdata;
	logic      host_irq;
	logic      sat_irq;
	integer    seed;
	int        checks;
	int        errors;
	int        mark_checks;
	int        mark_errors;
	int        cyc;

	`include "tb_ssm_tasks.svh"

	ssm_top #(.FIFO_AW(10), .TIMER_DIV(4)) UUT (
		.mclk(mclk), .st_ale(st_ale), .host(host), .sat(sat), .host_rdata(host_rdata),
		.host_irq(host_irq), .sat_rdata(sat_rdata), .sat_irq(sat_irq)
	);

	always #5 mclk = ~mclk;

	// Elapsed cycles for the timer bound
	always @(posedge mclk)
		cyc <= cyc + 1;

	initial
	begin
		word_t       d;
		word_t       v;
		word_t       hirq_m;
		word_t       mask_m;
		word_t       resp_w [4];
		word_t       cr_w [4];
		word_t       expq [$];
		logic [31:0] t1;
		logic [31:0] t2;
		int          t0;
		int          bound;

		seed = 32'h0432a275;
		checks = 0;
		errors = 0;
		mark_checks = 0;
		mark_errors = 0;
		cyc = 0;
		mclk = 1'b0;
		st_ale = 1'b1;
		host = '0;
		sat = '0;
		sat.cs2_n = 1'b1;
		sat.rd_n = 1'b1;
		sat.wr_n = 1'b1;
		repeat (4) @(posedge mclk);
		#1;
		st_ale = 1'b0;
		step(2);

		////////////////////////////////////////////////////////////
		// IDs and reset values
		////////////////////////////////////////////////////////////

		host_read(HA_ID, 1'b0, d);
		check_word("host_rdata[ID]", d, 16'h5253);
		host_read(HA_VER, 1'b0, d);
		check_word("host_rdata[VER]", d, 16'h1204);
		sat_read(WIN_REG, SI_ID, 1'b0, d);
		check_word("sat_rdata[ID]", d, 16'h5253);
		sat_read(WIN_REG, SI_ID, 1'b1, d);
		check_word("sat_rdata[VER]", d, 16'h1204);
		sat_read(WIN_REG, SI_CTRL, 1'b0, d);
		check_word("sat_rdata[CTRL]", d, 16'h0100);
		end_test("ids");

		////////////////////////////////////////////////////////////
		// Mailbox
		////////////////////////////////////////////////////////////

		for (int i = 0; i < 4; i++)
		begin
			resp_w[i] = rand_word();
			host_write(HA_RESPW + 8'(2 * i), resp_w[i]);
		end
		for (int i = 0; i < 4; i++)
		begin
			sat_read(WIN_CDC, CI_CR1 + 4'(i), 1'b0, d);
			check_word("sat_rdata[CR]", d, resp_w[i]);
		end
		for (int i = 0; i < 4; i++)
		begin
			cr_w[i] = rand_word();
			sat_write(WIN_CDC, CI_CR1 + 4'(i), cr_w[i]);
		end
		for (int i = 0; i < 4; i++)
		begin
			host_read(HA_CR + 8'(2 * i), 1'b0, d);
			check_word("host_rdata[CR]", d, cr_w[i]);
		end
		// cdc flag and in-command, irq still disabled
		host_read(HA_STAT, 1'b0, d);
		check_word("host_rdata[STAT]", d, 16'h1001);
		check_word("host_irq", 16'(host_irq), 16'h0000);
		host_write(HA_CTRL, 16'h0001);
		wait_host_irq(1'b1);
		host_write(HA_STAT, 16'h0001);
		wait_host_irq(1'b0);
		sat_read(WIN_CDC, CI_CR4, 1'b0, d);
		host_read(HA_STAT, 1'b0, d);
		check_word("host_rdata[STAT]", d, 16'h0000);
		host_write(HA_CTRL, 16'h0000);
		end_test("mailbox");

		////////////////////////////////////////////////////////////
		// hirq and mask against a model
		////////////////////////////////////////////////////////////

		hirq_m = 16'h0000;
		mask_m = 16'h0000;
		for (int i = 0; i < 12; i++)
		begin
			d = rand_word();
			case (i % 4)
				0:
				begin
					host_write(HA_HIRQ_SET, d);
					hirq_m = hirq_m | d;
				end
				1:
				begin
					sat_write(WIN_CDC, CI_MASK, d);
					mask_m = d;
				end
				2:
				begin
					host_write(HA_HIRQ_CLR, d);
					hirq_m = hirq_m & ~d;
				end
				default:
				begin
					sat_write(WIN_CDC, CI_HIRQ, d);
					hirq_m = hirq_m & d;
				end
			endcase
			host_read(HA_HIRQ_SET, 1'b0, d);
			check_word("host_rdata[HIRQ]", d, hirq_m);
			check_word("sat_irq", 16'(sat_irq), 16'(|(hirq_m & mask_m)));
		end
		host_read(HA_MASK, 1'b0, d);
		check_word("host_rdata[MASK]", d, mask_m);
		sat_read(WIN_CDC, CI_HIRQ, 1'b0, d);
		check_word("sat_rdata[HIRQ]", d, hirq_m);
		end_test("hirq");

		////////////////////////////////////////////////////////////
		// FIFO
		////////////////////////////////////////////////////////////

		// Host fills, console drains swapped
		for (int i = 0; i < 6; i++)
		begin
			d = rand_word();
			host_write(HA_FIFO, d);
			expq.push_back(swap_bytes(d));
		end
		host_read(HA_FSTAT, 1'b0, d);
		check_word("host_rdata[FSTAT]", d, 16'd6);
		for (int i = 0; i < 6; i++)
		begin
			sat_read(WIN_CDC, CI_FIFO, 1'b0, d);
			check_word("sat_rdata[FIFO]", d, expq.pop_front());
		end
		host_read(HA_STAT, 1'b0, d);
		check_word("host_rdata[STAT]", d, 16'h0004);
		host_write(HA_STAT, 16'h0004);

		// Console fills, host drains
		host_write(HA_CTRL, 16'h0200);
		for (int i = 0; i < 5; i++)
		begin
			d = rand_word();
			sat_write(WIN_CDC, CI_FIFO, d);
			expq.push_back(swap_bytes(d));
		end
		host_read(HA_FSTAT, 1'b0, d);
		check_word("host_rdata[FSTAT]", d, 16'd5);
		for (int i = 0; i < 5; i++)
		begin
			host_read(HA_FIFO, 1'b1, d);
			check_word("host_rdata[FIFO]", d, expq.pop_front());
		end
		host_read(HA_STAT, 1'b0, d);
		check_word("host_rdata[STAT]", d, 16'h0004);
		host_write(HA_STAT, 16'h0004);

		// FIFO reset through ctrl
		host_write(HA_CTRL, 16'h0000);
		for (int i = 0; i < 3; i++)
			host_write(HA_FIFO, rand_word());
		host_read(HA_FSTAT, 1'b0, d);
		check_word("host_rdata[FSTAT]", d, 16'd3);
		host_write(HA_CTRL, 16'h0100);
		host_write(HA_CTRL, 16'h0000);
		host_read(HA_FSTAT, 1'b0, d);
		check_word("host_rdata[FSTAT]", d, 16'd0);
		host_write(HA_STAT, 16'h0004);
		end_test("fifo");

		////////////////////////////////////////////////////////////
		// System registers
		////////////////////////////////////////////////////////////

		v = rand_word();
		sat_write(WIN_REG, SI_CMD, v);
		host_read(HA_SCMD, 1'b0, d);
		check_word("host_rdata[SCMD]", d, v);
		host_read(HA_STAT, 1'b0, d);
		check_word("host_rdata[STAT]", d, 16'h0002);
		host_write(HA_SCMD, 16'hffff);
		host_read(HA_SCMD, 1'b0, d);
		check_word("host_rdata[SCMD]", d, 16'h0000);
		host_write(HA_STAT, 16'h0002);

		// Data from the console, then from the host
		v = rand_word();
		sat_write(WIN_REG, SI_DATA, v);
		host_read(HA_SDATA, 1'b0, d);
		check_word("host_rdata[SDATA]", d, v);
		sat_read(WIN_REG, SI_DATA, 1'b0, d);
		check_word("sat_rdata[DATA]", d, v);
		v = rand_word();
		host_write(HA_SDATA, v);
		host_read(HA_SDATA, 1'b0, d);
		check_word("host_rdata[SDATA]", d, v);
		sat_read(WIN_REG, SI_DATA, 1'b0, d);
		check_word("sat_rdata[DATA]", d, v);

		// Timer clear, then two reads
		t0 = cyc;
		sat_write(WIN_REG, SI_TIMER, 16'h0000);
		read_timer(t1);
		bound = (cyc - t0) / 4 + 1;
		read_timer(t2);
		check_true(t1 < 32'(bound),
			$sformatf("ERROR timer %h not below bound %h", t1, bound));
		check_true(t2 >= t1,
			$sformatf("ERROR timer %h below earlier read %h", t2, t1));
		end_test("sysregs");

		$display("Checks: %0d, failed: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
